//--- Makefile
# verilator build and run for the intt core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module intt_tb

run: build
	./obj_dir/Vintt_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module intt_top

clean:
	rm -rf obj_dir sim.log

//--- dv/intt_properties.sv
// control and output properties for the intt core
// bound into intt_top, watches the decode phase and the outside outputs
`timescale 1ns/1ps

module intt_properties
    import intt_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input ctrl_t ctrl,
    input logic  busy,
    input logic  done,
    input coef_t dout
);

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // done only at the tail of a transform
    a_done_in_run: assert property (@(posedge clk) disable iff (reset)
        done |-> (busy && ctrl.phase == RUN))
        else $error("done pulsed outside the RUN phase");

    a_busy_drop: assert property (@(posedge clk) disable iff (reset)
        done |=> !busy)
        else $error("busy still high the cycle after done");

    a_dout_quiet: assert property (@(posedge clk) disable iff (reset)
        !busy |-> (dout == '0))    // readout only drives while busy
        else $error("dout nonzero while the core is idle");

endmodule

bind intt_top intt_properties u_props (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .busy  (busy),
    .done  (done),
    .dout  (dout)
);

//--- dv/intt_tb.sv
// testbench for the inverse ntt core
// vectors and expected results come from the tests file; covers plain
// transforms, repeated readout, a load ignored during RUN and reset mid-run
`timescale 1ns/1ps

module intt_tb
    import intt_pkg::*;
();

    localparam int LOG_N       = 4;
    localparam int N           = 1 << LOG_N;
    localparam int NUM_VEC     = 6;
    localparam int VEC_WORDS   = 2 * N;            // inputs, then expected
    localparam int PASS_CYCLES = 2 * N + LOG_N * (N / 2 + 8) + 20;
    localparam int MAX_CYCLES  = (NUM_VEC + 3) * PASS_CYCLES; // 3 extra passes

    logic  clk = 1'b0;
    logic  reset;
    logic  load_data;
    logic  start_intt;
    logic  output_data_single;
    coef_t din;
    logic  busy;
    logic  done;
    coef_t dout;

    coef_t  vec_mem [NUM_VEC * VEC_WORDS];
    integer seed = 32'he345_dc76;
    int     cycles;
    int     test_num;
    int     test_errs;
    int     passed;
    int     failed;
    int     mismatches;

    intt_top #(
        .LOG_N (LOG_N)
    ) u_dut (
        .clk                (clk),
        .reset              (reset),
        .load_data          (load_data),
        .start_intt         (start_intt),
        .output_data_single (output_data_single),
        .din                (din),
        .busy               (busy),
        .done               (done),
        .dout               (dout)
    );

    always #20 clk = ~clk;

    // run limit from the number of passes
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: timeout after %0d cycles, the DUT never finished", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input coef_t expected, input coef_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected 0x%04h got 0x%04h", name, expected, actual);
            test_errs++;
            mismatches++;
        end
    endtask

    task automatic check_quiet();
        check_value("busy", coef_t'(0), coef_t'(busy));
        check_value("done", coef_t'(0), coef_t'(done));
        check_value("dout", coef_t'(0), dout);
    endtask

    task automatic load_vector(input int vec);
        @(posedge clk);
        #2 load_data = 1'b1;
        @(posedge clk);
        #2 load_data = 1'b0;
        din = vec_mem[vec * VEC_WORDS];        // word 0 right after the pulse
        for (int k = 1; k < N; k++) begin
            @(posedge clk);
            #2 din = vec_mem[vec * VEC_WORDS + k];
        end
        @(posedge clk);
        #2 din = '0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2 start_intt = 1'b1;
        @(posedge clk);
        #2 start_intt = 1'b0;
    endtask

    // load command plus junk din while the transform runs
    task automatic poke_load_during_run();
        logic [31:0] junk;
        repeat (3) @(posedge clk);
        #2;
        check_value("busy", coef_t'(1), coef_t'(busy));
        junk      = $random(seed);
        load_data = 1'b1;
        din       = junk[DATA_W-1:0];
        @(posedge clk);
        #2 load_data = 1'b0;
        for (int k = 0; k < N; k++) begin
            @(posedge clk);
            #2 junk = $random(seed);
            din = junk[DATA_W-1:0];
        end
        din = '0;
    endtask

    task automatic wait_for_done();
        @(posedge clk);
        #1;
        while (done !== 1'b1) begin    // one look per cycle for the done pulse
            @(posedge clk);
            #1;
        end
        check_value("busy", coef_t'(1), coef_t'(busy));
    endtask

    task automatic read_and_check(input int vec);
        @(posedge clk);
        #2 output_data_single = 1'b1;
        @(posedge clk);
        #2 output_data_single = 1'b0;
        for (int k = 0; k < N; k++) begin  // word k after edge k + 2
            @(posedge clk);
            #1 check_value($sformatf("dout[%0d]", k), vec_mem[vec * VEC_WORDS + N + k], dout);
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (test_errs == 0) begin
            passed++;
            $display("test %0d (%s): pass", test_num, name);
        end else begin
            failed++;
            $display("test %0d (%s): FAIL with %0d errors", test_num, name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        logic [31:0] junk;
        int          bad_words;
        reset              = 1'b1;
        load_data          = 1'b0;
        start_intt         = 1'b0;
        output_data_single = 1'b0;
        din                = '0;
        bad_words          = 0;
        // words at or above q mark entries the file left unfilled
        for (int i = 0; i < NUM_VEC * VEC_WORDS; i++)
            vec_mem[i] = Q + coef_t'(i);
        $readmemh("dv/intt_tests.txt", vec_mem);
        for (int i = 0; i < NUM_VEC * VEC_WORDS; i++) begin
            if ($isunknown(vec_mem[i]) || vec_mem[i] >= Q)
                bad_words++;
        end
        assert (bad_words == 0) else begin
            $display("ERROR: %0d words of the test vector file are missing or out of range",
                     bad_words);
            failed++;
        end
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;

        for (int t = 0; t < NUM_VEC; t++) begin
            load_vector(t);
            pulse_start();
            wait_for_done();
            read_and_check(t);
            report_test((t == 0) ? "impulse" : $sformatf("transform of vector %0d", t));
        end

        // memory survives a readout
        read_and_check(NUM_VEC - 1);
        report_test("repeated readout");

        load_vector(2);
        pulse_start();
        poke_load_during_run();
        wait_for_done();
        read_and_check(2);
        report_test("load ignored during run");

        // async reset somewhere inside the run
        load_vector(4);
        pulse_start();
        junk = $random(seed);
        repeat (6 + junk[3:0]) @(posedge clk);
        #2 reset = 1'b1;
        #1 check_quiet();
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;
        @(posedge clk);
        #1 check_quiet();
        load_vector(3);
        pulse_start();
        wait_for_done();
        read_and_check(3);
        report_test("reset mid-run");

        $display("%0d tests run, %0d passed, %0d failed, %0d mismatches",
                 test_num, passed, failed, mismatches);
        if (failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/intt_tests.txt
// per test two lines: 16 input coefficients a[0..15], then 16 expected outputs
// x[0..15] = n^-1 * sum_k a[k] * w^(-j*k) mod 12289, w = 11^768, all in hex
0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
2D01 2D01 2D01 2D01 2D01 2D01 2D01 2D01 2D01 2D01 2D01 2D01 2D01 2D01 2D01 2D01
0001 1026 2036 2D2F 05C7 1999 141A 0519 3000 1FDB 0FCB 02D2 2A3A 1668 1BE7 2AE8
0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0001 2D2F 141A 1FDB 2A3A 2AE8 2036 1999 3000 02D2 1BE7 1026 05C7 0519 0FCB 1668
0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
000A 0004 000A 0004 000A 0004 000A 0004 000A 0004 000A 0004 000A 0004 000A 0004
0007 0000 0000 0000 0000 0000 0000 0000 0003 0000 0000 0000 0000 0000 0000 0000
0001 2AE8 1BE7 1668 2A3A 02D2 0FCB 1FDB 3000 0519 141A 1999 05C7 2D2F 2036 1026
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001
0004 199C 0FCE 2AEB 05CA 1FDE 1BEA 2D32 0002 166B 2039 051C 2A3D 1029 141D 02D5
0003 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

//--- hdl/gs_butterfly.sv
// gentleman-sande butterfly, three pipeline stages
// x = a + b, y = (a - b) * w, all mod q; write addresses ride along
`timescale 1ns/1ps

module gs_butterfly
    import intt_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  bfly_op_t  op,
    output bfly_res_t res
);

    logic                s1_valid, s2_valid, s3_valid;
    coef_t               s1_x, s1_d, s1_w;
    coef_t               s2_x;
    logic [2*DATA_W-1:0] s2_prod;     // raw product before reduction
    coef_t               s3_x, s3_y;
    addr_t               s1_ax, s1_ay;
    addr_t               s2_ax, s2_ay;
    addr_t               s3_ax, s3_ay;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= op.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        // add and subtract
        s1_x  <= mod_add(op.a, op.b);
        s1_d  <= mod_sub(op.a, op.b);
        s1_w  <= op.w;
        s1_ax <= op.addr_a;
        s1_ay <= op.addr_b;
        // integer multiply
        s2_x    <= s1_x;
        s2_prod <= s1_d * s1_w;
        s2_ax   <= s1_ax;
        s2_ay   <= s1_ay;
        // reduce mod q
        s3_x  <= s2_x;
        s3_y  <= mod_red(s2_prod);
        s3_ax <= s2_ax;
        s3_ay <= s2_ay;
    end

    always_comb begin
        res.x      = s3_x;
        res.y      = s3_y;
        res.addr_x = s3_ax;
        res.addr_y = s3_ay;
        res.valid  = s3_valid;
    end

endmodule

//--- hdl/intt_decode.sv
// intt command decoder
// phase fsm with a cycle counter, started by single-cycle command pulses.
// LOAD and READ end at fixed counts, RUN ends on the execute unit's finish
`timescale 1ns/1ps

module intt_decode
    import intt_pkg::*;
#(
    parameter int LOG_N = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_data,
    input  logic  start_intt,
    input  logic  output_data_single,
    input  logic  run_finished,
    output ctrl_t ctrl,
    output logic  busy,
    output logic  done
);

    localparam int N = 1 << LOG_N;

    phase_e phase;
    cnt_t   cnt;
    logic   run_start;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= IDLE;
            cnt       <= '0;
            run_start <= 1'b0;
            done      <= 1'b0;
        end else begin
            run_start <= 1'b0;   // both are single-cycle pulses
            done      <= 1'b0;
            case (phase)
                IDLE: begin
                    cnt <= '0;
                    // commands only seen here, read beats load beats start
                    if (output_data_single) begin
                        phase <= READ;
                    end else if (load_data) begin
                        phase <= LOAD;
                    end else if (start_intt) begin
                        phase     <= RUN;
                        run_start <= 1'b1;
                    end
                end
                LOAD: begin
                    if (cnt == CNT_W'(N - 1)) begin // last din word
                        phase <= IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RUN: begin
                    if (done)
                        phase <= IDLE;      // busy drops right after done
                    else if (run_finished)
                        done <= 1'b1;
                end
                READ: begin
                    // one extra count so the last dout word stays inside READ
                    if (cnt == CNT_W'(N)) begin
                        phase <= IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    always_comb begin
        ctrl.phase     = phase;
        ctrl.cnt       = cnt;
        ctrl.run_start = run_start;
    end

    assign busy = (phase != IDLE);

endmodule

//--- hdl/intt_execute.sv
// intt execute unit
// coefficient register file with two read and two write ports, plus the
// gentleman-sande schedule: one butterfly per cycle, in place, stage by stage,
// with a pipeline drain between stages
`timescale 1ns/1ps

module intt_execute
    import intt_pkg::*;
#(
    parameter int LOG_N = 4
) (
    input  logic    clk,
    input  logic    reset,
    input  ctrl_t   ctrl,
    input  coef_t   din,
    input  mem_rd_t rd,
    output coef_t   rd_data,
    output logic    run_finished
);

    localparam int N     = 1 << LOG_N;
    localparam int STG_W = $clog2(LOG_N);
    localparam int WT_W  = $clog2(BFLY_LAT);

    coef_t mem [N];
    coef_t tw_rom [N/2];            // inverse twiddles, built at elaboration

    logic               issuing;    // butterflies going out this cycle
    logic               draining;   // waiting on the last writebacks
    logic [STG_W-1:0]   stage;
    logic [LOG_N-2:0]   bf_idx;     // butterfly within the stage
    logic [WT_W-1:0]    wait_cnt;

    logic [LOG_N-1:0]   span;
    logic [LOG_N-1:0]   pos;
    logic [LOG_N-1:0]   addr_a;
    logic [LOG_N-1:0]   addr_b;
    logic [LOG_N-1:0]   tw_idx;
    logic [LOG_N-1:0]   rd_addr0;
    coef_t              port0;

    bfly_op_t  op;
    bfly_res_t res;

    for (genvar i = 0; i < N/2; i++) begin : g_tw
        assign tw_rom[i] = inv_twiddle(i, LOG_N);
    end

    // pair addresses, a zero bit inserted at the span position
    always_comb begin
        span     = LOG_N'(N/2) >> stage;                 // n >> (s+1)
        pos      = LOG_N'(bf_idx) & (span - 1'b1);
        addr_a   = ((LOG_N'(bf_idx) & ~(span - 1'b1)) << 1) | pos;
        addr_b   = addr_a | span;
        tw_idx   = pos << stage;                         // w^-(pos * 2^s)
        rd_addr0 = issuing ? addr_a : rd.addr[LOG_N-1:0];
        port0    = mem[rd_addr0];
    end

    always_comb begin
        op.a      = port0;
        op.b      = mem[addr_b];
        op.w      = tw_rom[tw_idx[LOG_N-2:0]];
        op.addr_a = ADDR_W'(addr_a);
        op.addr_b = ADDR_W'(addr_b);
        op.valid  = issuing;
    end

    gs_butterfly u_bfly (
        .clk   (clk),
        .reset (reset),
        .op    (op),
        .res   (res)
    );

    // write port 0 shared by din in LOAD and x in RUN
    always_ff @(posedge clk) begin
        if (ctrl.phase == LOAD)
            mem[ctrl.cnt[LOG_N-1:0]] <= din;
        else if (res.valid)
            mem[res.addr_x[LOG_N-1:0]] <= res.x;
        if (res.valid)
            mem[res.addr_y[LOG_N-1:0]] <= res.y;
        rd_data <= port0;                                // readout port
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issuing      <= 1'b0;
            draining     <= 1'b0;
            stage        <= '0;
            bf_idx       <= '0;
            wait_cnt     <= '0;
            run_finished <= 1'b0;
        end else begin
            run_finished <= 1'b0;
            if (ctrl.run_start) begin
                issuing <= 1'b1;
                stage   <= '0;
                bf_idx  <= '0;
            end else if (issuing) begin
                if (bf_idx == (LOG_N-1)'(N/2 - 1)) begin  // last pair of the stage
                    issuing  <= 1'b0;
                    draining <= 1'b1;
                    bf_idx   <= '0;
                    wait_cnt <= '0;
                end else begin
                    bf_idx <= bf_idx + 1'b1;
                end
            end else if (draining) begin
                if (wait_cnt == WT_W'(BFLY_LAT - 1)) begin // last writeback now
                    draining <= 1'b0;
                    if (stage == STG_W'(LOG_N - 1)) begin
                        run_finished <= 1'b1;
                    end else begin
                        stage   <= stage + 1'b1;
                        issuing <= 1'b1;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/intt_pkg.sv
// intt package
// constants, bus structs and modulo-q arithmetic for the inverse ntt core.
// the twiddle and n^-1 functions are evaluated at elaboration
package intt_pkg;

    localparam int DATA_W    = 14;
    localparam int BFLY_LAT  = 3;           // butterfly pipeline depth
    localparam int MAX_LOG_N = 10;          // largest ring supported
    localparam int ADDR_W    = MAX_LOG_N;
    localparam int CNT_W     = MAX_LOG_N + 1; // room for a count of n

    localparam logic [DATA_W-1:0] Q = DATA_W'(12289);
    localparam int unsigned GEN = 11;       // primitive root mod q

    typedef logic [DATA_W-1:0] coef_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    typedef enum logic [1:0] {IDLE, LOAD, RUN, READ} phase_e;

    typedef struct packed {
        phase_e phase;
        cnt_t   cnt;        // cycles spent in LOAD or READ
        logic   run_start;  // first cycle of RUN
    } ctrl_t;

    typedef struct packed {
        coef_t a;
        coef_t b;
        coef_t w;
        addr_t addr_a;      // written back with x
        addr_t addr_b;      // written back with y
        logic  valid;
    } bfly_op_t;

    typedef struct packed {
        coef_t x;
        coef_t y;
        addr_t addr_x;
        addr_t addr_y;
        logic  valid;
    } bfly_res_t;

    typedef struct packed {
        addr_t addr;
    } mem_rd_t;

    function automatic coef_t mod_add(coef_t a, coef_t b);
        logic [DATA_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, Q})
            s = s - {1'b0, Q};
        return s[DATA_W-1:0];
    endfunction

    function automatic coef_t mod_sub(coef_t a, coef_t b);
        return (a >= b) ? a - b : a + (Q - b); // wrap through q
    endfunction

    function automatic coef_t mod_red(logic [2*DATA_W-1:0] p);
        return coef_t'(p % Q);
    endfunction

    function automatic coef_t mod_mul(coef_t a, coef_t b);
        logic [2*DATA_W-1:0] p;
        p = a * b;
        return mod_red(p);
    endfunction

    // square and multiply, q^2 fits in 32 bits
    function automatic int unsigned pow_mod(int unsigned base, int unsigned e);
        int unsigned r;
        int unsigned b;
        r = 1;
        b = base % Q;
        for (int i = 0; i < 32; i++) begin
            if (e[i])
                r = (r * b) % Q;
            b = (b * b) % Q;
        end
        return r;
    endfunction

    // w^-k with w = 11^((q-1)/n)
    function automatic coef_t inv_twiddle(int unsigned k, int unsigned log_n);
        int unsigned n;
        int unsigned w;
        int unsigned w_inv;
        n     = 1 << log_n;
        w     = pow_mod(GEN, (Q - 1) >> log_n);
        w_inv = pow_mod(w, n - 1);        // w^n = 1
        return coef_t'(pow_mod(w_inv, k));
    endfunction

    function automatic coef_t n_inv(int unsigned log_n);
        return coef_t'(pow_mod(1 << log_n, Q - 2)); // fermat inverse
    endfunction

endpackage

//--- hdl/intt_result.sv
// intt result path
// reads the memory in bit-reversed order and scales by n^-1, so dout
// streams the transform in natural order, one word per cycle
`timescale 1ns/1ps

module intt_result
    import intt_pkg::*;
#(
    parameter int LOG_N = 4
) (
    input  logic    clk,
    input  logic    reset,
    input  ctrl_t   ctrl,
    output mem_rd_t rd,
    input  coef_t   rd_data,
    output coef_t   dout
);

    localparam int    N     = 1 << LOG_N;
    localparam coef_t N_INV = n_inv(LOG_N);

    logic [LOG_N-1:0] seq;     // natural index being fetched
    logic [LOG_N-1:0] rev;

    // address runs one word ahead of the count, word 0 already sits
    // at the port in IDLE so the first value lands two cycles after the pulse
    always_comb begin
        seq = (ctrl.phase == READ) ? LOG_N'(ctrl.cnt + 1'b1) : '0;
        for (int i = 0; i < LOG_N; i++)
            rev[i] = seq[LOG_N-1-i];
        rd.addr = ADDR_W'(rev);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            dout <= '0;
        else if (ctrl.phase == READ && ctrl.cnt < CNT_W'(N))
            dout <= mod_mul(rd_data, N_INV);
        else
            dout <= '0;        // quiet outside readout
    end

endmodule

//--- hdl/intt_top.sv
// intt core top level
// 2^LOG_N point inverse ntt mod 12289: serial load, in-place transform,
// serial scaled readout
`timescale 1ns/1ps

module intt_top
    import intt_pkg::*;
#(
    parameter int LOG_N = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_data,
    input  logic  start_intt,
    input  logic  output_data_single,
    input  coef_t din,
    output logic  busy,
    output logic  done,
    output coef_t dout
);

    ctrl_t   ctrl;
    logic    run_finished;
    mem_rd_t rd;
    coef_t   rd_data;

    intt_decode #(
        .LOG_N (LOG_N)
    ) u_decode (
        .clk                (clk),
        .reset              (reset),
        .load_data          (load_data),
        .start_intt         (start_intt),
        .output_data_single (output_data_single),
        .run_finished       (run_finished),
        .ctrl               (ctrl),
        .busy               (busy),
        .done               (done)
    );

    intt_execute #(
        .LOG_N (LOG_N)
    ) u_execute (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .din          (din),
        .rd           (rd),
        .rd_data      (rd_data),
        .run_finished (run_finished)
    );

    intt_result #(
        .LOG_N (LOG_N)
    ) u_result (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .rd      (rd),
        .rd_data (rd_data),
        .dout    (dout)
    );

endmodule

//--- list.f
hdl/intt_pkg.sv
hdl/gs_butterfly.sv
hdl/intt_decode.sv
hdl/intt_execute.sv
hdl/intt_result.sv
hdl/intt_top.sv
dv/intt_properties.sv
dv/intt_tb.sv
